// ==== Bender.yml ====
package:
  name: scary_maze

sources:
  - verilog/maze_game_pkg.sv
  - verilog/vga_pkg.sv
  - verilog/vga_timing.sv
  - verilog/menu_decode.sv
  - verilog/game_fsm.sv
  - verilog/layer_select.sv
  - verilog/scary_maze_top.sv
  - target: test
    files:
      - verif/scary_maze_tb.sv

// ==== scary_maze.f ====
verilog/maze_game_pkg.sv
verilog/vga_pkg.sv
verilog/vga_timing.sv
verilog/menu_decode.sv
verilog/game_fsm.sv
verilog/layer_select.sv
verilog/scary_maze_top.sv
verif/scary_maze_tb.sv

// ==== verif/scary_maze_tb.sv ====
`timescale 1ns/1ns

module scary_maze_tb;

    localparam int LINE_CLKS = (vga_pkg::H_DISPLAY + vga_pkg::H_FRONT + vga_pkg::H_SYNC
        + vga_pkg::H_BACK) * vga_pkg::TICK_DIV;

    typedef enum {s_next, s_up, s_down, s_control, s_collide, s_goal} strobe_e;

    logic clk;
    logic reset;
    logic btn_next_i;
    logic btn_up_i;
    logic btn_down_i;
    logic btn_control_i;
    logic collide_i;
    logic goal_i;
    vga_pkg::rgb_t title_rgb_i;
    vga_pkg::rgb_t menu_rgb_i;
    vga_pkg::rgb_t hud_rgb_i;
    vga_pkg::rgb_t maze_rgb_i;
    vga_pkg::rgb_t pointer_rgb_i;
    vga_pkg::rgb_t gameover_rgb_i;
    vga_pkg::rgb_t final_rgb_i;
    logic menu_on_i;
    logic maze_on_i;
    logic pointer_on_i;
    vga_pkg::rgb_t rgb_o;
    logic hsync_o;
    logic vsync_o;
    maze_game_pkg::game_state_e game_state_o;
    maze_game_pkg::lives_t lives_o;
    maze_game_pkg::level_t level_sel_o;
    logic pointer_restart_o;
    int errors;
    int checks;
    bit [7:0] colour_used;

    scary_maze_top scary_maze_top_i
    (
        .clk               (clk),
        .reset             (reset),
        .btn_next_i        (btn_next_i),
        .btn_up_i          (btn_up_i),
        .btn_down_i        (btn_down_i),
        .btn_control_i     (btn_control_i),
        .collide_i         (collide_i),
        .goal_i            (goal_i),
        .title_rgb_i       (title_rgb_i),
        .menu_rgb_i        (menu_rgb_i),
        .hud_rgb_i         (hud_rgb_i),
        .maze_rgb_i        (maze_rgb_i),
        .pointer_rgb_i     (pointer_rgb_i),
        .gameover_rgb_i    (gameover_rgb_i),
        .final_rgb_i       (final_rgb_i),
        .menu_on_i         (menu_on_i),
        .maze_on_i         (maze_on_i),
        .pointer_on_i      (pointer_on_i),
        .rgb_o             (rgb_o),
        .hsync_o           (hsync_o),
        .vsync_o           (vsync_o),
        .game_state_o      (game_state_o),
        .lives_o           (lives_o),
        .level_sel_o       (level_sel_o),
        .pointer_restart_o (pointer_restart_o)
    );

    // 100 ns period
    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ------------------------------
    // Compare tasks
    // ------------------------------
    task automatic compare_state(input string name, input maze_game_pkg::game_state_e exp,
        input maze_game_pkg::game_state_e got);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[FAIL] %0t %s expected %s got %s (%0d)", $time, name, exp.name(),
                got.name(), got);
        end
    endtask

    task automatic compare_lives(input string name, input maze_game_pkg::lives_t exp,
        input maze_game_pkg::lives_t got);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[FAIL] %0t %s expected %0d got %0d", $time, name, exp, got);
        end
    endtask

    task automatic compare_level(input string name, input maze_game_pkg::level_t exp,
        input maze_game_pkg::level_t got);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[FAIL] %0t %s expected %0d got %0d", $time, name, exp, got);
        end
    endtask

    task automatic compare_rgb(input string name, input vga_pkg::rgb_t exp,
        input vga_pkg::rgb_t got);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[FAIL] %0t %s expected %b got %b", $time, name, exp, got);
        end
    endtask

    task automatic compare_count(input string name, input int exp, input int got);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[FAIL] %0t %s expected %0d got %0d", $time, name, exp, got);
        end
    endtask

    // ------------------------------
    // Stimulus helpers
    // ------------------------------
    task automatic apply_reset();
        @(posedge clk);
        reset <= 1'b1;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
    endtask

    // One-cycle strobe, then settle to the next falling edge
    task automatic press(input strobe_e which);
        @(posedge clk);
        case (which)
            s_next:    btn_next_i <= 1'b1;
            s_up:      btn_up_i <= 1'b1;
            s_down:    btn_down_i <= 1'b1;
            s_control: btn_control_i <= 1'b1;
            s_collide: collide_i <= 1'b1;
            default:   goal_i <= 1'b1;
        endcase
        @(posedge clk);
        btn_next_i <= 1'b0;
        btn_up_i <= 1'b0;
        btn_down_i <= 1'b0;
        btn_control_i <= 1'b0;
        collide_i <= 1'b0;
        goal_i <= 1'b0;
        @(negedge clk);
    endtask

    task automatic set_enables(input logic menu_on, input logic maze_on, input logic pointer_on);
        @(posedge clk);
        menu_on_i <= menu_on;
        maze_on_i <= maze_on;
        pointer_on_i <= pointer_on;
        @(negedge clk);
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("Timeout: the %s never came", what);
    endtask

    // Wait for hsync_o to change to the wanted level
    task automatic wait_hsync(input logic level, input string what);
        logic prev;
        bit seen;
        int n;
        prev = hsync_o;
        seen = 1'b0;
        for (n = 0; n < 2 * LINE_CLKS && !seen; n++)
        begin
            @(negedge clk);
            if (hsync_o === level && prev !== level)
                seen = 1'b1;
            prev = hsync_o;
        end
        if (!seen)
            report_timeout(what);
    endtask

    // Pulse high now, low one cycle later
    task automatic check_restart_pulse();
        compare_count("pointer_restart_o", 1, pointer_restart_o);
        @(negedge clk);
        compare_count("pointer_restart_o", 0, pointer_restart_o);
    endtask

    task automatic end_test(input string name, input int start_errors);
        $display("%s: %0d errors", name, errors - start_errors);
    endtask

    // Distinct and never black, so each layer and the blanking stay visible
    function automatic vga_pkg::rgb_t pick_colour();
        int c;
        int k;
        c = ($urandom % 7) + 1;
        for (k = 0; k < 7 && colour_used[c]; k++)
            c = (c % 7) + 1;
        colour_used[c] = 1'b1;
        return vga_pkg::rgb_t'(c);
    endfunction

    function automatic maze_game_pkg::game_state_e level_state(input int lv);
        case (lv)
            0: return maze_game_pkg::state_level_1;
            1: return maze_game_pkg::state_level_2;
            default: return maze_game_pkg::state_level_3;
        endcase
    endfunction

    // Priority rule per state
    function automatic vga_pkg::rgb_t expected_rgb(input maze_game_pkg::game_state_e st);
        case (st)
            maze_game_pkg::state_menu:
                return menu_on_i ? menu_rgb_i : title_rgb_i;
            maze_game_pkg::state_game_over:
                return gameover_rgb_i;
            maze_game_pkg::state_scary:
                return final_rgb_i;
            default:
            begin
                if (pointer_on_i)
                    return pointer_rgb_i;
                if (maze_on_i)
                    return maze_rgb_i;
                return hud_rgb_i;
            end
        endcase
    endfunction

    // Sample mid line, then inside the sync pulse
    task automatic check_layer(input maze_game_pkg::game_state_e st, input string what);
        compare_state("game_state_o", st, game_state_o);
        wait_hsync(1'b1, "end of the hsync_o pulse");
        repeat ((vga_pkg::H_BACK + 4) * vga_pkg::TICK_DIV) @(negedge clk);
        compare_rgb(what, expected_rgb(st), rgb_o);
        wait_hsync(1'b0, "start of the hsync_o pulse");
        repeat (vga_pkg::TICK_DIV + 1) @(negedge clk);
        compare_rgb("rgb_o during hsync", '0, rgb_o);
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------
    task automatic reset_values();
        int start_errors;
        start_errors = errors;
        compare_state("game_state_o", maze_game_pkg::state_menu, game_state_o);
        compare_lives("lives_o", maze_game_pkg::INIT_LIVES, lives_o);
        compare_level("level_sel_o", 2'd0, level_sel_o);
        compare_count("pointer_restart_o", 0, pointer_restart_o);
        compare_rgb("rgb_o", '0, rgb_o);
        // Both sync outputs idle high
        compare_count("hsync_o", 1, hsync_o);
        compare_count("vsync_o", 1, vsync_o);
        end_test("reset values", start_errors);
    endtask

    task automatic level_selection();
        int start_errors;
        int i;
        int lv;
        maze_game_pkg::level_t up_seq [4];
        maze_game_pkg::level_t down_seq [4];
        start_errors = errors;
        // Wraps from 2 to 0 going up and from 0 to 2 going down
        up_seq = '{2'd1, 2'd2, 2'd0, 2'd1};
        down_seq = '{2'd0, 2'd2, 2'd1, 2'd0};
        apply_reset();
        for (i = 0; i < 4; i++)
        begin
            press(s_up);
            compare_level("level_sel_o after up", up_seq[i], level_sel_o);
        end
        for (i = 0; i < 4; i++)
        begin
            press(s_down);
            compare_level("level_sel_o after down", down_seq[i], level_sel_o);
        end
        // Next starts the chosen level
        for (lv = 0; lv <= 2; lv++)
        begin
            apply_reset();
            repeat (lv) press(s_up);
            press(s_next);
            compare_state("game_state_o after next", level_state(lv), game_state_o);
            check_restart_pulse();
        end
        end_test("level selection", start_errors);
    endtask

    task automatic progression();
        int start_errors;
        int i;
        maze_game_pkg::game_state_e order [4];
        start_errors = errors;
        order = '{maze_game_pkg::state_level_1, maze_game_pkg::state_level_2,
            maze_game_pkg::state_level_3, maze_game_pkg::state_scary};
        apply_reset();
        press(s_next);
        compare_state("game_state_o", order[0], game_state_o);
        for (i = 1; i < 4; i++)
        begin
            press(s_goal);
            compare_state("game_state_o after goal", order[i], game_state_o);
            check_restart_pulse();
        end
        // End screen ignores everything
        for (i = 0; i < 6; i++)
        begin
            press(strobe_e'(i));
            compare_state("game_state_o in end screen", maze_game_pkg::state_scary,
                game_state_o);
            compare_count("pointer_restart_o", 0, pointer_restart_o);
        end
        end_test("level progression", start_errors);
    endtask

    task automatic lives_and_restart();
        int start_errors;
        int i;
        maze_game_pkg::lives_t exp;
        start_errors = errors;
        apply_reset();
        press(s_next);
        press(s_control);
        compare_lives("lives_o after control", maze_game_pkg::INIT_LIVES, lives_o);
        compare_state("game_state_o after control", maze_game_pkg::state_level_1,
            game_state_o);
        check_restart_pulse();
        exp = maze_game_pkg::INIT_LIVES;
        for (i = 0; i < int'(maze_game_pkg::INIT_LIVES); i++)
        begin
            press(s_collide);
            exp = exp - 2'd1;
            compare_lives("lives_o after collide", exp, lives_o);
            check_restart_pulse();
            if (exp != 2'd0)
                compare_state("game_state_o", maze_game_pkg::state_level_1, game_state_o);
        end
        compare_state("game_state_o", maze_game_pkg::state_game_over, game_state_o);
        press(s_goal);
        press(s_control);
        compare_state("game_state_o held", maze_game_pkg::state_game_over, game_state_o);
        end_test("lives and restart", start_errors);
    endtask

    task automatic layer_priority();
        int start_errors;
        start_errors = errors;
        apply_reset();
        set_enables(1'b0, 1'b0, 1'b0);
        check_layer(maze_game_pkg::state_menu, "title layer");
        set_enables(1'b1, 1'b1, 1'b1);
        check_layer(maze_game_pkg::state_menu, "menu layer");
        press(s_next);
        check_layer(maze_game_pkg::state_level_1, "pointer layer");
        set_enables(1'b1, 1'b1, 1'b0);
        check_layer(maze_game_pkg::state_level_1, "maze layer");
        set_enables(1'b1, 1'b0, 1'b0);
        check_layer(maze_game_pkg::state_level_1, "hud layer");
        repeat (int'(maze_game_pkg::INIT_LIVES)) press(s_collide);
        set_enables(1'b1, 1'b1, 1'b1);
        check_layer(maze_game_pkg::state_game_over, "game over layer");
        apply_reset();
        press(s_next);
        repeat (3) press(s_goal);
        check_layer(maze_game_pkg::state_scary, "final layer");
        end_test("layer priority", start_errors);
    endtask

    task automatic hsync_timing();
        int start_errors;
        int width;
        int period;
        bit done;
        start_errors = errors;
        wait_hsync(1'b0, "falling edge of hsync_o");
        width = 0;
        done = 1'b0;
        while (!done && width < LINE_CLKS)
        begin
            @(negedge clk);
            width++;
            done = hsync_o;
        end
        if (!done)
            report_timeout("rising edge of hsync_o");
        compare_count("hsync_o low cycles", vga_pkg::H_SYNC * vga_pkg::TICK_DIV, width);
        period = width;
        done = 1'b0;
        while (!done && period < 2 * LINE_CLKS)
        begin
            @(negedge clk);
            period++;
            done = !hsync_o;
        end
        if (!done)
            report_timeout("next falling edge of hsync_o");
        compare_count("hsync_o edge spacing", LINE_CLKS, period);
        end_test("horizontal timing", start_errors);
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial
    begin
        int unsigned seed;
        errors = 0;
        checks = 0;
        colour_used = '0;
        reset <= 1'b1;
        btn_next_i <= 1'b0;
        btn_up_i <= 1'b0;
        btn_down_i <= 1'b0;
        btn_control_i <= 1'b0;
        collide_i <= 1'b0;
        goal_i <= 1'b0;
        menu_on_i <= 1'b0;
        maze_on_i <= 1'b0;
        pointer_on_i <= 1'b0;
        seed = 32'h65eb_1e67;
        void'($urandom(seed));
        title_rgb_i <= pick_colour();
        menu_rgb_i <= pick_colour();
        hud_rgb_i <= pick_colour();
        maze_rgb_i <= pick_colour();
        pointer_rgb_i <= pick_colour();
        gameover_rgb_i <= pick_colour();
        final_rgb_i <= pick_colour();
        apply_reset();
        reset_values();
        level_selection();
        progression();
        lives_and_restart();
        layer_priority();
        hsync_timing();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== verilog/game_fsm.sv ====
`timescale 1ns/1ns

module game_fsm
(
    input  logic                       clk,
    input  logic                       reset,
    input  maze_game_pkg::game_cmd_e   cmd_i,
    input  maze_game_pkg::level_t      level_sel_i,
    input  logic                       collide_i,
    input  logic                       goal_i,
    output maze_game_pkg::game_state_e game_state_o,
    output maze_game_pkg::lives_t      lives_o,
    output logic                       pointer_restart_o
);

    maze_game_pkg::game_state_e state_q;
    maze_game_pkg::game_state_e state_d;
    maze_game_pkg::game_state_e start_state;
    maze_game_pkg::lives_t lives_q;
    maze_game_pkg::lives_t lives_d;
    logic restart_q;
    logic restart_d;

    // Entry level picked in the menu
    always_comb
    begin
        case (level_sel_i)
            2'd0: start_state = maze_game_pkg::state_level_1;
            2'd1: start_state = maze_game_pkg::state_level_2;
            default: start_state = maze_game_pkg::state_level_3;
        endcase
    end

    // ------------------------------
    // Next state and lives
    // ------------------------------
    always_comb
    begin
        state_d = state_q;
        lives_d = lives_q;
        restart_d = 1'b0;
        // Decoder only issues start from the menu
        if (cmd_i == maze_game_pkg::cmd_start)
        begin
            state_d = start_state;
            restart_d = 1'b1;
        end
        else
        begin
            case (state_q)
                maze_game_pkg::state_level_1,
                maze_game_pkg::state_level_2,
                maze_game_pkg::state_level_3:
                begin
                    if (goal_i)
                    begin
                        // Goal beats a collision in the same cycle
                        case (state_q)
                            maze_game_pkg::state_level_1: state_d = maze_game_pkg::state_level_2;
                            maze_game_pkg::state_level_2: state_d = maze_game_pkg::state_level_3;
                            default: state_d = maze_game_pkg::state_scary;
                        endcase
                    end
                    else if (collide_i)
                    begin
                        lives_d = lives_q - 1'b1;
                        // Last life gone
                        if (lives_q == 2'd1)
                            state_d = maze_game_pkg::state_game_over;
                    end
                    restart_d = goal_i | collide_i | (cmd_i == maze_game_pkg::cmd_restart);
                end
                // Menu waits for start, end screens hold until reset
                default:
                    state_d = state_q;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state_q <= maze_game_pkg::state_menu;
            lives_q <= maze_game_pkg::INIT_LIVES;
            restart_q <= 1'b0;
        end
        else
        begin
            state_q <= state_d;
            lives_q <= lives_d;
            restart_q <= restart_d;
        end
    end

    assign game_state_o = state_q;
    assign lives_o = lives_q;
    assign pointer_restart_o = restart_q;

endmodule

// ==== verilog/layer_select.sv ====
`timescale 1ns/1ns

module layer_select
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       pixel_tick_i,
    input  logic                       video_on_i,
    input  maze_game_pkg::game_state_e game_state_i,
    input  vga_pkg::rgb_t              title_rgb_i,
    input  vga_pkg::rgb_t              menu_rgb_i,
    input  vga_pkg::rgb_t              hud_rgb_i,
    input  vga_pkg::rgb_t              maze_rgb_i,
    input  vga_pkg::rgb_t              pointer_rgb_i,
    input  vga_pkg::rgb_t              gameover_rgb_i,
    input  vga_pkg::rgb_t              final_rgb_i,
    input  logic                       menu_on_i,
    input  logic                       maze_on_i,
    input  logic                       pointer_on_i,
    output vga_pkg::rgb_t              rgb_o
);

    vga_pkg::rgb_t layer_rgb;
    vga_pkg::rgb_t pix_q;
    vga_pkg::rgb_t rgb_q;

    // ------------------------------
    // Layer priority per state
    // ------------------------------
    always_comb
    begin
        case (game_state_i)
            // Menu text over the title picture
            maze_game_pkg::state_menu:
                layer_rgb = menu_on_i ? menu_rgb_i : title_rgb_i;
            maze_game_pkg::state_level_1,
            maze_game_pkg::state_level_2,
            maze_game_pkg::state_level_3:
            begin
                // Pointer, then walls, then lives panel
                if (pointer_on_i)
                    layer_rgb = pointer_rgb_i;
                else if (maze_on_i)
                    layer_rgb = maze_rgb_i;
                else
                    layer_rgb = hud_rgb_i;
            end
            maze_game_pkg::state_game_over:
                layer_rgb = gameover_rgb_i;
            maze_game_pkg::state_scary:
                layer_rgb = final_rgb_i;
            default:
                layer_rgb = '0;
        endcase
    end

    // Sample once per pixel, blank outside the display area
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pix_q <= '0;
            rgb_q <= '0;
        end
        else
        begin
            if (pixel_tick_i)
                pix_q <= layer_rgb;
            rgb_q <= video_on_i ? pix_q : '0;
        end
    end

    assign rgb_o = rgb_q;

endmodule

// ==== verilog/maze_game_pkg.sv ====
package maze_game_pkg;

    // ------------------------------
    // Play states
    // ------------------------------
    typedef enum logic [2:0]
    {
        state_menu,
        state_level_1,
        state_level_2,
        state_level_3,
        state_game_over,
        state_scary
    } game_state_e;

    // ------------------------------
    // Decoded button commands
    // ------------------------------
    typedef enum logic [1:0]
    {
        cmd_none,
        cmd_start,
        cmd_restart
    } game_cmd_e;

    // Starting level, 0 to LAST_LEVEL
    typedef logic [1:0] level_t;
    typedef logic [1:0] lives_t;

    localparam lives_t INIT_LIVES = 2'd3;
    localparam level_t LAST_LEVEL = 2'd2;

endpackage

// ==== verilog/menu_decode.sv ====
`timescale 1ns/1ns

module menu_decode
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      btn_next_i,
    input  logic                      btn_up_i,
    input  logic                      btn_down_i,
    input  logic                      btn_control_i,
    input  maze_game_pkg::game_state_e game_state_i,
    output maze_game_pkg::level_t      level_sel_o,
    output maze_game_pkg::game_cmd_e   cmd_o
);

    maze_game_pkg::level_t level_q;

    // ------------------------------
    // Level selection cursor
    // ------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
            level_q <= '0;
        else if (game_state_i == maze_game_pkg::state_menu)
        begin
            // Up wins when both strobes coincide
            if (btn_up_i)
                level_q <= (level_q == maze_game_pkg::LAST_LEVEL) ? '0 : level_q + 1'b1;
            else if (btn_down_i)
                level_q <= (level_q == '0) ? maze_game_pkg::LAST_LEVEL : level_q - 1'b1;
        end
    end

    assign level_sel_o = level_q;

    // ------------------------------
    // Command decode
    // ------------------------------
    always_comb
    begin
        cmd_o = maze_game_pkg::cmd_none;
        case (game_state_i)
            maze_game_pkg::state_menu:
                if (btn_next_i)
                    cmd_o = maze_game_pkg::cmd_start;
            // Control puts the pointer back during play
            maze_game_pkg::state_level_1,
            maze_game_pkg::state_level_2,
            maze_game_pkg::state_level_3:
                if (btn_control_i)
                    cmd_o = maze_game_pkg::cmd_restart;
            default:
                cmd_o = maze_game_pkg::cmd_none;
        endcase
    end

endmodule

// ==== verilog/scary_maze_top.sv ====
`timescale 1ns/1ns

module scary_maze_top
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       btn_next_i,
    input  logic                       btn_up_i,
    input  logic                       btn_down_i,
    input  logic                       btn_control_i,
    input  logic                       collide_i,
    input  logic                       goal_i,
    input  vga_pkg::rgb_t              title_rgb_i,
    input  vga_pkg::rgb_t              menu_rgb_i,
    input  vga_pkg::rgb_t              hud_rgb_i,
    input  vga_pkg::rgb_t              maze_rgb_i,
    input  vga_pkg::rgb_t              pointer_rgb_i,
    input  vga_pkg::rgb_t              gameover_rgb_i,
    input  vga_pkg::rgb_t              final_rgb_i,
    input  logic                       menu_on_i,
    input  logic                       maze_on_i,
    input  logic                       pointer_on_i,
    output vga_pkg::rgb_t              rgb_o,
    output logic                       hsync_o,
    output logic                       vsync_o,
    output maze_game_pkg::game_state_e game_state_o,
    output maze_game_pkg::lives_t      lives_o,
    output maze_game_pkg::level_t      level_sel_o,
    output logic                       pointer_restart_o
);

    logic pixel_tick;
    logic video_on;
    maze_game_pkg::game_cmd_e cmd;
    maze_game_pkg::level_t level_sel;
    maze_game_pkg::game_state_e game_state;

    // ------------------------------
    // Timing and control
    // ------------------------------
    vga_timing vga_timing_i
    (
        .clk          (clk),
        .reset        (reset),
        .pixel_tick_o (pixel_tick),
        .video_on_o   (video_on),
        .hsync_o      (hsync_o),
        .vsync_o      (vsync_o)
    );

    menu_decode menu_decode_i
    (
        .clk           (clk),
        .reset         (reset),
        .btn_next_i    (btn_next_i),
        .btn_up_i      (btn_up_i),
        .btn_down_i    (btn_down_i),
        .btn_control_i (btn_control_i),
        .game_state_i  (game_state),
        .level_sel_o   (level_sel),
        .cmd_o         (cmd)
    );

    game_fsm game_fsm_i
    (
        .clk               (clk),
        .reset             (reset),
        .cmd_i             (cmd),
        .level_sel_i       (level_sel),
        .collide_i         (collide_i),
        .goal_i            (goal_i),
        .game_state_o      (game_state),
        .lives_o           (lives_o),
        .pointer_restart_o (pointer_restart_o)
    );

    // ------------------------------
    // Pixel output
    // ------------------------------
    layer_select layer_select_i
    (
        .clk            (clk),
        .reset          (reset),
        .pixel_tick_i   (pixel_tick),
        .video_on_i     (video_on),
        .game_state_i   (game_state),
        .title_rgb_i    (title_rgb_i),
        .menu_rgb_i     (menu_rgb_i),
        .hud_rgb_i      (hud_rgb_i),
        .maze_rgb_i     (maze_rgb_i),
        .pointer_rgb_i  (pointer_rgb_i),
        .gameover_rgb_i (gameover_rgb_i),
        .final_rgb_i    (final_rgb_i),
        .menu_on_i      (menu_on_i),
        .maze_on_i      (maze_on_i),
        .pointer_on_i   (pointer_on_i),
        .rgb_o          (rgb_o)
    );

    // State and level go out to the picture generators
    assign game_state_o = game_state;
    assign level_sel_o = level_sel;

endmodule

// ==== verilog/vga_pkg.sv ====
package vga_pkg;

    // One bit per channel, R G B
    typedef logic [2:0] rgb_t;
    typedef logic [9:0] pixel_coord_t;

    // ------------------------------
    // Pixel clock divider
    // ------------------------------
    localparam int TICK_DIV = 4;
    localparam int TICK_W = $clog2(TICK_DIV);
    typedef logic [TICK_W-1:0] tick_cnt_t;

    // ------------------------------
    // Horizontal timing, in pixels
    // ------------------------------
    localparam int H_DISPLAY = 640;
    localparam int H_FRONT = 16;
    localparam int H_SYNC = 96;
    localparam int H_BACK = 48;
    localparam int H_TOTAL = H_DISPLAY + H_FRONT + H_SYNC + H_BACK;

    // ------------------------------
    // Vertical timing, in lines
    // ------------------------------
    localparam int V_DISPLAY = 480;
    localparam int V_FRONT = 10;
    localparam int V_SYNC = 2;
    localparam int V_BACK = 33;
    localparam int V_TOTAL = V_DISPLAY + V_FRONT + V_SYNC + V_BACK;

endpackage

// ==== verilog/vga_timing.sv ====
`timescale 1ns/1ns

module vga_timing
(
    input  logic clk,
    input  logic reset,
    output logic pixel_tick_o,
    output logic video_on_o,
    output logic hsync_o,
    output logic vsync_o
);

    vga_pkg::tick_cnt_t tick_cnt;
    vga_pkg::pixel_coord_t h_count;
    vga_pkg::pixel_coord_t v_count;
    logic tick;
    logic h_last;
    logic v_last;

    // ------------------------------
    // Pixel tick divider
    // ------------------------------
    // One tick on the last count of each divide period
    assign tick = (tick_cnt == vga_pkg::tick_cnt_t'(vga_pkg::TICK_DIV - 1));

    always_ff @(posedge clk)
    begin
        if (reset)
            tick_cnt <= '0;
        else if (tick)
            tick_cnt <= '0;
        else
            tick_cnt <= tick_cnt + 1'b1;
    end

    // ------------------------------
    // Column and row counters
    // ------------------------------
    assign h_last = (h_count == vga_pkg::pixel_coord_t'(vga_pkg::H_TOTAL - 1));
    assign v_last = (v_count == vga_pkg::pixel_coord_t'(vga_pkg::V_TOTAL - 1));

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            h_count <= '0;
            v_count <= '0;
        end
        else if (tick)
        begin
            // Row steps once per finished line
            if (h_last)
            begin
                h_count <= '0;
                v_count <= v_last ? '0 : v_count + 1'b1;
            end
            else
                h_count <= h_count + 1'b1;
        end
    end

    // Sync pulses active low, inside the blanking interval
    assign hsync_o = ~((h_count >= vga_pkg::pixel_coord_t'(vga_pkg::H_DISPLAY + vga_pkg::H_FRONT))
        && (h_count < vga_pkg::pixel_coord_t'(vga_pkg::H_DISPLAY + vga_pkg::H_FRONT
        + vga_pkg::H_SYNC)));
    assign vsync_o = ~((v_count >= vga_pkg::pixel_coord_t'(vga_pkg::V_DISPLAY + vga_pkg::V_FRONT))
        && (v_count < vga_pkg::pixel_coord_t'(vga_pkg::V_DISPLAY + vga_pkg::V_FRONT
        + vga_pkg::V_SYNC)));

    // Visible area only
    assign video_on_o = (h_count < vga_pkg::pixel_coord_t'(vga_pkg::H_DISPLAY))
        && (v_count < vga_pkg::pixel_coord_t'(vga_pkg::V_DISPLAY));
    assign pixel_tick_o = tick;

endmodule
